// File: files.f
logic/acq_pkg.sv
logic/acq_ctrl_if.sv
logic/circ_buf_wr.sv
logic/readout_seq.sv
logic/readout_addr.sv
logic/frame_out.sv
logic/acq_readout_top.sv
verif/acq_assert.sv
verif/acq_monitor.sv
verif/acq_tb.sv

// File: logic/acq_ctrl_if.sv
`default_nettype none

interface acq_ctrl_if;
    // read-side strobes
    logic init_circ_buf_rd_addr;   // load read address from trigger address
    logic inc_circ_buf_rd_addr;
    logic latch_circ_buf_dat;      // shift one buffer word into the burst
    logic burst_cntr_init;
    logic burst_cntr_en;
    logic waveform_cntr_init;
    logic waveform_cntr_en;
    logic burst_adr_cntr_init;     // ddr3 address back to 1 at fill start
    logic burst_adr_cntr_en;
    logic save_start_adr;
    logic save_last_adr;
    logic fill_cntr_en;
    // output-side strobes
    logic select_waveform_hdr;
    logic select_dat;
    logic select_fill_hdr;
    logic select_checksum;
    logic checksum_init;
    logic checksum_update;
    logic acq_out_valid;           // mux register holds a word for the ddr3 fifo

    modport seq (
        output init_circ_buf_rd_addr, inc_circ_buf_rd_addr, latch_circ_buf_dat,
        output burst_cntr_init, burst_cntr_en, waveform_cntr_init, waveform_cntr_en,
        output burst_adr_cntr_init, burst_adr_cntr_en, save_start_adr, save_last_adr,
        output fill_cntr_en, select_waveform_hdr, select_dat, select_fill_hdr,
        output select_checksum, checksum_init, checksum_update, acq_out_valid
    );
    modport addr (
        input init_circ_buf_rd_addr, inc_circ_buf_rd_addr, latch_circ_buf_dat,
        input burst_cntr_init, burst_cntr_en, waveform_cntr_init, waveform_cntr_en,
        input burst_adr_cntr_init, burst_adr_cntr_en, save_start_adr, save_last_adr,
        input fill_cntr_en
    );
    modport out (
        input select_waveform_hdr, select_dat, select_fill_hdr, select_checksum,
        input checksum_init, checksum_update, acq_out_valid
    );
endinterface

`default_nettype wire

// File: logic/acq_pkg.sv
`default_nettype none

package acq_pkg;
    localparam int adc_word_w          = 32;    // two 12-bit samples per word
    localparam int cbuf_addr_w         = 8;
    localparam int cbuf_depth          = 1 << cbuf_addr_w;
    localparam int trig_fifo_depth     = 8;
    localparam int trig_fifo_aw        = $clog2(trig_fifo_depth);
    localparam int drop_cnt_w          = 8;
    localparam int pre_trig_words      = 8;     // words kept ahead of the trigger point
    localparam int bursts_per_waveform = 4;
    localparam int burst_cnt_w         = $clog2(bursts_per_waveform + 1);
    localparam int out_word_w          = 128;
    localparam int words_per_burst     = out_word_w / adc_word_w;
    localparam int word_cnt_w          = $clog2(words_per_burst);
    localparam int ddr_adr_w           = 24;

    // header layout, 32-bit lanes of the 128-bit word
    localparam int lane_w    = 32;
    localparam int lane_tag  = 0;
    localparam int lane_num  = 1;   // waveform number / fill number
    localparam int lane_info = 2;   // trigger address / waveform count
    localparam int lane_adr  = 3;   // ddr3 start / last burst address
    localparam logic [lane_w-1:0] wfm_hdr_tag  = 32'h5746_4d48;
    localparam logic [lane_w-1:0] fill_hdr_tag = 32'h4649_4c4c;

    // bit positions of the one-hot readout sequencer
    localparam int seq_states = 17;
    typedef enum logic [4:0] {
        s_idle, s_fill_init1, s_trig_wait,
        s_wfm_init1, s_wfm_init2, s_wfm_init3,
        s_loop1, s_loop2, s_loop3, s_loop4,
        s_wfm_done1, s_wfm_done2,
        s_fill_done1, s_fill_done2, s_fill_done3, s_fill_done4,
        s_done
    } seq_idx_e;
endpackage

`default_nettype wire

// File: logic/acq_readout_top.sv
`default_nettype none

module acq_readout_top (
    input  wire logic                           adc_clk,
    input  wire logic                           reset_clk_adc,
    input  wire logic [acq_pkg::adc_word_w-1:0] adc_dat,
    input  wire logic                           trig,
    input  wire logic                           cbuf_rd_en,
    input  wire logic                           cbuf_trig_en,
    output logic      [acq_pkg::out_word_w-1:0] acq_out_dat,
    output logic                                acq_out_valid,
    output logic                                cbuf_rd_trig_wait,
    output logic      [acq_pkg::drop_cnt_w-1:0] trig_drop_cnt
);
    import acq_pkg::*;

    logic [cbuf_addr_w-1:0] trig_addr;
    logic                   trig_fifo_empty;
    logic                   trig_addr_rd_en;
    logic [cbuf_addr_w-1:0] cbuf_rd_addr;
    logic [adc_word_w-1:0]  cbuf_rd_dat;
    logic                   burst_cntr_zero;
    logic [out_word_w-1:0]  burst_dat;
    logic [lane_w-1:0]      waveform_num;
    logic [lane_w-1:0]      fill_num;
    logic [cbuf_addr_w-1:0] trig_addr_saved;
    logic [ddr_adr_w-1:0]   start_adr;
    logic [ddr_adr_w-1:0]   last_adr;

    acq_ctrl_if ctrl ();    // sequencer strobes

    circ_buf_wr u_circ_buf_wr (
        .adc_clk, .reset_clk_adc, .adc_dat, .trig, .cbuf_trig_en, .trig_addr_rd_en,
        .cbuf_rd_addr, .cbuf_rd_dat, .trig_addr, .trig_fifo_empty, .trig_drop_cnt
    );

    readout_seq u_readout_seq (
        .adc_clk, .reset_clk_adc, .cbuf_rd_en, .cbuf_trig_en, .trig_fifo_empty,
        .burst_cntr_zero, .cbuf_rd_trig_wait, .trig_addr_rd_en, .ctrl(ctrl.seq)
    );

    readout_addr u_readout_addr (
        .adc_clk, .reset_clk_adc, .trig_addr, .cbuf_rd_dat, .ctrl(ctrl.addr),
        .cbuf_rd_addr, .burst_cntr_zero, .burst_dat, .waveform_num, .fill_num,
        .trig_addr_saved, .start_adr, .last_adr
    );

    frame_out u_frame_out (
        .adc_clk, .reset_clk_adc, .burst_dat, .waveform_num, .fill_num, .trig_addr_saved,
        .start_adr, .last_adr, .ctrl(ctrl.out), .acq_out_dat, .acq_out_valid
    );
endmodule

`default_nettype wire

// File: logic/circ_buf_wr.sv
`default_nettype none

module circ_buf_wr (
    input  wire logic                            adc_clk,
    input  wire logic                            reset_clk_adc,
    input  wire logic [acq_pkg::adc_word_w-1:0]  adc_dat,
    input  wire logic                            trig,
    input  wire logic                            cbuf_trig_en,
    input  wire logic                            trig_addr_rd_en,
    input  wire logic [acq_pkg::cbuf_addr_w-1:0] cbuf_rd_addr,
    output logic      [acq_pkg::adc_word_w-1:0]  cbuf_rd_dat,
    output logic      [acq_pkg::cbuf_addr_w-1:0] trig_addr,
    output logic                                 trig_fifo_empty,
    output logic      [acq_pkg::drop_cnt_w-1:0]  trig_drop_cnt
);
    import acq_pkg::*;

    logic [adc_word_w-1:0]  cbuf_mem [cbuf_depth];
    logic [cbuf_addr_w-1:0] wr_addr;                      // wraps, buffer is a power of two
    logic [cbuf_addr_w-1:0] trig_fifo [trig_fifo_depth];
    logic [trig_fifo_aw:0]  fifo_wr_ptr;                  // msb tells full from empty
    logic [trig_fifo_aw:0]  fifo_rd_ptr;
    logic                   trig_fifo_full;
    logic                   trig_hit;                     // qualified trigger this cycle

    assign trig_hit        = trig && cbuf_trig_en;
    assign trig_fifo_empty = (fifo_wr_ptr == fifo_rd_ptr);
    assign trig_fifo_full  = (fifo_wr_ptr[trig_fifo_aw] != fifo_rd_ptr[trig_fifo_aw]) &&
                             (fifo_wr_ptr[trig_fifo_aw-1:0] == fifo_rd_ptr[trig_fifo_aw-1:0]);
    assign trig_addr       = trig_fifo[fifo_rd_ptr[trig_fifo_aw-1:0]];  // fwft head

    // adc words go in every clock, read port has one cycle latency
    always_ff @(posedge adc_clk) begin
        cbuf_mem[wr_addr] <= adc_dat;
        cbuf_rd_dat       <= cbuf_mem[cbuf_rd_addr];
        if (trig_hit && !trig_fifo_full)
            trig_fifo[fifo_wr_ptr[trig_fifo_aw-1:0]] <= wr_addr;  // address written this cycle
    end

    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) begin
            wr_addr       <= '0;
            fifo_wr_ptr   <= '0;
            fifo_rd_ptr   <= '0;
            trig_drop_cnt <= '0;
        end else begin
            wr_addr <= wr_addr + 1'b1;
            if (trig_hit && !trig_fifo_full)
                fifo_wr_ptr <= fifo_wr_ptr + 1'b1;
            if (trig_addr_rd_en && !trig_fifo_empty)
                fifo_rd_ptr <= fifo_rd_ptr + 1'b1;
            // fifo full, trigger lost; counter sticks at all ones
            if (trig_hit && trig_fifo_full && (trig_drop_cnt != '1))
                trig_drop_cnt <= trig_drop_cnt + 1'b1;
        end
    end
endmodule

`default_nettype wire

// File: logic/frame_out.sv
`default_nettype none

module frame_out (
    input  wire logic                            adc_clk,
    input  wire logic                            reset_clk_adc,
    input  wire logic [acq_pkg::out_word_w-1:0]  burst_dat,
    input  wire logic [acq_pkg::lane_w-1:0]      waveform_num,
    input  wire logic [acq_pkg::lane_w-1:0]      fill_num,
    input  wire logic [acq_pkg::cbuf_addr_w-1:0] trig_addr_saved,
    input  wire logic [acq_pkg::ddr_adr_w-1:0]   start_adr,
    input  wire logic [acq_pkg::ddr_adr_w-1:0]   last_adr,
    acq_ctrl_if.out                              ctrl,
    output logic      [acq_pkg::out_word_w-1:0]  acq_out_dat,
    output logic                                 acq_out_valid
);
    import acq_pkg::*;

    logic [out_word_w-1:0] wfm_hdr;
    logic [out_word_w-1:0] fill_hdr;
    logic [out_word_w-1:0] mux_dat;         // registered mux, like the ddr3 fifo input
    logic [lane_w-1:0]     checksum;
    logic                  sel_checksum_d;  // second fill header select follows the checksum

    // wrapping 32-bit sum over all lanes of a word
    function automatic logic [lane_w-1:0] lane_sum(input logic [out_word_w-1:0] w);
        logic [lane_w-1:0] s;
        s = '0;
        for (int i = 0; i < out_word_w / lane_w; i++) begin
            s += w[i*lane_w +: lane_w];
        end
        return s;
    endfunction

    always_comb begin
        wfm_hdr                              = '0;
        wfm_hdr[lane_tag*lane_w +: lane_w]   = wfm_hdr_tag;
        wfm_hdr[lane_num*lane_w +: lane_w]   = waveform_num;
        wfm_hdr[lane_info*lane_w +: lane_w]  = lane_w'(trig_addr_saved);
        wfm_hdr[lane_adr*lane_w +: lane_w]   = lane_w'(start_adr);
        fill_hdr                             = '0;
        fill_hdr[lane_tag*lane_w +: lane_w]  = fill_hdr_tag;
        fill_hdr[lane_num*lane_w +: lane_w]  = fill_num;
        fill_hdr[lane_info*lane_w +: lane_w] = waveform_num;   // waveforms in this fill
        fill_hdr[lane_adr*lane_w +: lane_w]  = lane_w'(last_adr);
    end

    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) begin
            checksum       <= '0;
            sel_checksum_d <= 1'b0;
            acq_out_valid  <= 1'b0;
        end else begin
            sel_checksum_d <= ctrl.select_checksum;
            acq_out_valid  <= ctrl.acq_out_valid;
            if (ctrl.checksum_init)
                checksum <= '0;
            else if (ctrl.checksum_update)
                checksum <= checksum + lane_sum(burst_dat);
            else if (ctrl.select_waveform_hdr)
                checksum <= checksum + lane_sum(wfm_hdr);
            else if (ctrl.select_fill_hdr && !sel_checksum_d)
                checksum <= checksum + lane_sum(fill_hdr);  // counted once, before the checksum word
        end
    end

    always_ff @(posedge adc_clk) begin
        if (ctrl.select_waveform_hdr)
            mux_dat <= wfm_hdr;
        else if (ctrl.select_fill_hdr)
            mux_dat <= fill_hdr;
        else if (ctrl.select_checksum)
            mux_dat <= out_word_w'(checksum);   // sum in lane 0, upper lanes zero
        else if (ctrl.select_dat)
            mux_dat <= burst_dat;
        acq_out_dat <= mux_dat;                 // lines up with the registered valid
    end
endmodule

`default_nettype wire

// File: logic/readout_addr.sv
`default_nettype none

module readout_addr (
    input  wire logic                            adc_clk,
    input  wire logic                            reset_clk_adc,
    input  wire logic [acq_pkg::cbuf_addr_w-1:0] trig_addr,
    input  wire logic [acq_pkg::adc_word_w-1:0]  cbuf_rd_dat,
    acq_ctrl_if.addr                             ctrl,
    output logic      [acq_pkg::cbuf_addr_w-1:0] cbuf_rd_addr,
    output logic                                 burst_cntr_zero,
    output logic      [acq_pkg::out_word_w-1:0]  burst_dat,
    output logic      [acq_pkg::lane_w-1:0]      waveform_num,
    output logic      [acq_pkg::lane_w-1:0]      fill_num,
    output logic      [acq_pkg::cbuf_addr_w-1:0] trig_addr_saved,
    output logic      [acq_pkg::ddr_adr_w-1:0]   start_adr,
    output logic      [acq_pkg::ddr_adr_w-1:0]   last_adr
);
    import acq_pkg::*;

    logic [burst_cnt_w-1:0]           burst_cnt;   // bursts still to take
    logic [word_cnt_w-1:0]            word_cnt;    // words in the burst so far
    logic [out_word_w-adc_word_w-1:0] shift_dat;   // oldest word ends up in lane 0
    logic [ddr_adr_w-1:0]             burst_adr;   // next free ddr3 burst

    assign burst_cntr_zero = (burst_cnt == '0);

    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) begin
            cbuf_rd_addr <= '0;
            burst_cnt    <= '0;
            word_cnt     <= '0;
            waveform_num <= '0;
            fill_num     <= '0;
            burst_adr    <= '0;
        end else begin
            if (ctrl.init_circ_buf_rd_addr)
                cbuf_rd_addr <= trig_addr - cbuf_addr_w'(pre_trig_words);  // wraps
            else if (ctrl.inc_circ_buf_rd_addr)
                cbuf_rd_addr <= cbuf_rd_addr + 1'b1;
            if (ctrl.burst_cntr_init)
                burst_cnt <= burst_cnt_w'(bursts_per_waveform);
            else if (ctrl.burst_cntr_en)
                burst_cnt <= burst_cnt - 1'b1;
            if (ctrl.burst_cntr_init)
                word_cnt <= '0;
            else if (ctrl.latch_circ_buf_dat)
                word_cnt <= word_cnt + 1'b1;
            if (ctrl.waveform_cntr_init)
                waveform_num <= '0;
            else if (ctrl.waveform_cntr_en)
                waveform_num <= waveform_num + 1'b1;       // first waveform is 1
            if (ctrl.fill_cntr_en)
                fill_num <= fill_num + 1'b1;
            if (ctrl.burst_adr_cntr_init)
                burst_adr <= ddr_adr_w'(1);
            else if (ctrl.burst_adr_cntr_en)
                burst_adr <= burst_adr + 1'b1;
        end
    end

    always_ff @(posedge adc_clk) begin
        if (ctrl.latch_circ_buf_dat) begin
            shift_dat <= {cbuf_rd_dat, shift_dat[out_word_w-adc_word_w-1:adc_word_w]};
            if (word_cnt == word_cnt_w'(words_per_burst - 1))
                burst_dat <= {cbuf_rd_dat, shift_dat};     // held for four clocks
        end
        if (ctrl.init_circ_buf_rd_addr)
            trig_addr_saved <= trig_addr;
        if (ctrl.save_start_adr)
            start_adr <= burst_adr;                        // header goes here
        if (ctrl.save_last_adr)
            last_adr <= burst_adr;
    end
endmodule

`default_nettype wire

// File: logic/readout_seq.sv
`default_nettype none

module readout_seq (
    input  wire logic adc_clk,
    input  wire logic reset_clk_adc,
    input  wire logic cbuf_rd_en,          // readout enabled
    input  wire logic cbuf_trig_en,        // fill closes when this drops
    input  wire logic trig_fifo_empty,
    input  wire logic burst_cntr_zero,     // last burst of the waveform taken
    output logic      cbuf_rd_trig_wait,
    output logic      trig_addr_rd_en,
    acq_ctrl_if.seq   ctrl
);
    import acq_pkg::*;

    logic [seq_states-1:0] cs;
    logic [seq_states-1:0] ns;
    logic immed_valid;         // header and checksum words, valid one clock later
    logic start_dlyd_valid;    // burst complete, valid goes out after the pipeline
    logic delay0;
    logic dlyd_valid;

    // next state; reset forces idle here so the registered strobes clear too
    always_comb begin
        ns = '0;
        if (reset_clk_adc) begin
            ns[s_idle] = 1'b1;
        end else begin
            case (1'b1)
                cs[s_idle]: begin
                    if (cbuf_rd_en)
                        ns[s_fill_init1] = 1'b1;
                    else
                        ns[s_idle] = 1'b1;
                end
                cs[s_fill_init1]: ns[s_trig_wait] = 1'b1;
                cs[s_trig_wait]: begin
                    if (!trig_fifo_empty)
                        ns[s_wfm_init1] = 1'b1;    // queued triggers beat the fill end
                    else if (!cbuf_trig_en)
                        ns[s_fill_done1] = 1'b1;
                    else
                        ns[s_trig_wait] = 1'b1;
                end
                cs[s_wfm_init1]: ns[s_wfm_init2] = 1'b1;
                cs[s_wfm_init2]: ns[s_wfm_init3] = 1'b1;
                cs[s_wfm_init3]: ns[s_loop1] = 1'b1;
                cs[s_loop1]: ns[s_loop2] = 1'b1;
                cs[s_loop2]: ns[s_loop3] = 1'b1;
                cs[s_loop3]: ns[s_loop4] = 1'b1;
                cs[s_loop4]: begin
                    if (burst_cntr_zero)
                        ns[s_wfm_done1] = 1'b1;
                    else
                        ns[s_loop1] = 1'b1;        // next four words
                end
                cs[s_wfm_done1]: ns[s_wfm_done2] = 1'b1;
                cs[s_wfm_done2]: ns[s_trig_wait] = 1'b1;
                cs[s_fill_done1]: ns[s_fill_done2] = 1'b1;
                cs[s_fill_done2]: ns[s_fill_done3] = 1'b1;
                cs[s_fill_done3]: ns[s_fill_done4] = 1'b1;
                cs[s_fill_done4]: ns[s_done] = 1'b1;
                cs[s_done]: ns[s_idle] = 1'b1;
                default: ns[s_idle] = 1'b1;        // broken one-hot vector
            endcase
        end
    end

    // strobes registered from ns, high for the whole cycle of their state
    always_ff @(posedge adc_clk) begin
        cs                         <= ns;
        cbuf_rd_trig_wait          <= ns[s_trig_wait];
        trig_addr_rd_en            <= ns[s_wfm_init1];   // fwft pop
        ctrl.burst_adr_cntr_init   <= ns[s_fill_init1];
        ctrl.checksum_init         <= ns[s_fill_init1];
        ctrl.waveform_cntr_init    <= ns[s_fill_init1];
        ctrl.init_circ_buf_rd_addr <= ns[s_wfm_init1];
        ctrl.save_start_adr        <= ns[s_wfm_init1];
        ctrl.burst_cntr_init       <= ns[s_wfm_init1];
        ctrl.waveform_cntr_en      <= ns[s_wfm_init1];
        ctrl.select_waveform_hdr   <= ns[s_wfm_init2];
        immed_valid                <= ns[s_wfm_init3] | ns[s_fill_done2] | ns[s_fill_done3];
        ctrl.burst_adr_cntr_en     <= ns[s_wfm_init3] | ns[s_loop4] | ns[s_fill_done2];
        ctrl.inc_circ_buf_rd_addr  <= ns[s_wfm_init3] | (|ns[s_loop4:s_loop1]);
        ctrl.latch_circ_buf_dat    <= |ns[s_loop4:s_loop1];
        ctrl.select_dat            <= |ns[s_wfm_done2:s_loop1];  // loops and waveform done
        ctrl.burst_cntr_en         <= ns[s_loop1];
        start_dlyd_valid           <= ns[s_loop4];
        ctrl.save_last_adr         <= ns[s_wfm_done1];
        ctrl.select_fill_hdr       <= ns[s_fill_done1] | ns[s_fill_done3];
        ctrl.select_checksum       <= ns[s_fill_done2];
        ctrl.fill_cntr_en          <= ns[s_done];
    end

    // burst valid trails the last word latch by three clocks
    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) begin
            delay0               <= 1'b0;
            dlyd_valid           <= 1'b0;
            ctrl.checksum_update <= 1'b0;
            ctrl.acq_out_valid   <= 1'b0;
        end else begin
            delay0               <= start_dlyd_valid;
            dlyd_valid           <= delay0;
            ctrl.checksum_update <= delay0;      // burst register is stable by now
            ctrl.acq_out_valid   <= immed_valid | dlyd_valid;
        end
    end
endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build with verilator, then run and look for the pass line
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module acq_tb -o acq_sim \
    && ./obj_dir/acq_sim | tee /dev/stderr | grep -q "All checks passed" \
    && echo "simulation result: PASS" \
    || { echo "simulation result: FAIL"; exit 1; }

// File: verif/acq_assert.sv
`default_nettype none

module acq_assert (
    input wire logic                           adc_clk,
    input wire logic                           reset_clk_adc,
    input wire logic [acq_pkg::seq_states-1:0] cs,
    input wire logic                           sel_wfm_hdr,
    input wire logic                           sel_dat,
    input wire logic                           sel_fill_hdr,
    input wire logic                           sel_checksum,
    input wire logic                           out_valid
);
    timeunit 1ns;
    timeprecision 100ps;
    import acq_pkg::*;

    int fail_cnt = 0;   // failed assertions so far

    a_state_onehot: assert property (@(posedge adc_clk) disable iff (reset_clk_adc)
        $onehot(cs)) else begin
        $error("sequencer state not one-hot");
        fail_cnt++;
    end
    // one source for the output mux at a time
    a_select_excl: assert property (@(posedge adc_clk) disable iff (reset_clk_adc)
        $onehot0({sel_wfm_hdr, sel_dat, sel_fill_hdr, sel_checksum})) else begin
        $error("output select strobes overlap");
        fail_cnt++;
    end
    // valid pipeline drained whenever the sequencer sits in idle, right after reset too
    a_valid_idle: assert property (@(posedge adc_clk) disable iff (reset_clk_adc)
        cs[s_idle] |-> !out_valid) else begin
        $error("output valid high while the sequencer is idle");
        fail_cnt++;
    end
endmodule

bind readout_seq acq_assert u_acq_assert (
    .adc_clk, .reset_clk_adc, .cs(cs), .sel_wfm_hdr(ctrl.select_waveform_hdr),
    .sel_dat(ctrl.select_dat), .sel_fill_hdr(ctrl.select_fill_hdr),
    .sel_checksum(ctrl.select_checksum), .out_valid(ctrl.acq_out_valid)
);

`default_nettype wire

// File: verif/acq_monitor.sv
`default_nettype none

module acq_monitor (
    input  wire logic                            adc_clk,
    input  wire logic                            reset_clk_adc,
    input  wire logic [acq_pkg::adc_word_w-1:0]  adc_dat,
    input  wire logic                            trig,
    input  wire logic                            cbuf_trig_en,
    input  wire logic [acq_pkg::out_word_w-1:0]  acq_out_dat,
    input  wire logic                            acq_out_valid,
    input  wire logic                            cbuf_rd_trig_wait,
    input  wire logic [acq_pkg::drop_cnt_w-1:0]  trig_drop_cnt,
    output int                                   err_cnt = 0,
    output int                                   chk_cnt = 0,
    output int                                   fill_cnt = 0
);
    timeunit 1ns;
    timeprecision 100ps;
    import acq_pkg::*;

    logic [adc_word_w-1:0] hist [$];   // every word by write count
    int                    trig_q [$]; // write counts of queued triggers
    int                    drops = 0;
    int                    phase = 0;  // 0 header or checksum, 1..4 burst, 5 fill header
    int                    cur_t;
    int                    wfm_in_fill = 0;
    int                    fill_errs = 0;
    logic [lane_w-1:0]     csum = '0;
    bit                    wait_seen = 0;

    function automatic logic [lane_w-1:0] sum_lanes(input logic [out_word_w-1:0] w);
        logic [lane_w-1:0] s;
        s = '0;
        for (int i = 0; i < 4; i++)
            s = s + w[i*32 +: 32];
        return s;
    endfunction

    task automatic compare(input string sig, input logic [out_word_w-1:0] exp,
                           input logic [out_word_w-1:0] act);
        chk_cnt++;
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, sig, exp, act);
            err_cnt++;
            fill_errs++;
        end
    endtask

    task automatic fault(input string msg);
        $display("%0t: %s", $time, msg);
        err_cnt++;
        fill_errs++;
    endtask

    task automatic check_word(input logic [out_word_w-1:0] w);
        logic [out_word_w-1:0] exp;
        int idx;
        int last;
        last = 1 + wfm_in_fill * (bursts_per_waveform + 1);  // header plus bursts per waveform
        if (phase == 0 && trig_q.size() > 0) begin
            if (!wait_seen)
                fault("cbuf_rd_trig_wait never rose before the waveform header");
            wait_seen = 0;
            cur_t = trig_q.pop_front();
            wfm_in_fill++;
            exp = {32'(last), 32'(cur_t % cbuf_depth), 32'(wfm_in_fill), wfm_hdr_tag};
            compare("acq_out_dat (waveform header)", exp, w);
            csum = csum + sum_lanes(exp);
            phase = 1;
        end else if (phase == 0) begin
            if (!wait_seen)
                fault("cbuf_rd_trig_wait never rose before the fill end");
            exp = {32'(last), 32'(wfm_in_fill), 32'(fill_cnt), fill_hdr_tag};
            csum = csum + sum_lanes(exp);                     // fill header counts too
            compare("acq_out_dat (checksum)", {96'b0, csum}, w);
            phase = 5;
        end else if (phase <= bursts_per_waveform) begin
            for (int j = 0; j < 4; j++) begin
                idx = cur_t - pre_trig_words + 4 * (phase - 1) + j;
                exp[j*32 +: 32] = (idx >= 0 && idx < hist.size()) ? hist[idx] : 'x;
            end
            compare("acq_out_dat (data burst)", exp, w);
            csum = csum + sum_lanes(exp);
            phase = (phase == bursts_per_waveform) ? 0 : phase + 1;
        end else begin
            exp = {32'(last), 32'(wfm_in_fill), 32'(fill_cnt), fill_hdr_tag};
            compare("acq_out_dat (fill header)", exp, w);
            compare("trig_drop_cnt", out_word_w'(drops), out_word_w'(trig_drop_cnt));
            $display("fill %0d: %0d waveforms, %0d drops so far, %0d errors", fill_cnt,
                     wfm_in_fill, drops, fill_errs);
            fill_cnt++;
            wfm_in_fill = 0;
            fill_errs = 0;
            csum = '0;
            phase = 0;
        end
    endtask

    always @(posedge adc_clk) begin
        if (!reset_clk_adc) begin
            if (trig && cbuf_trig_en) begin
                if (trig_q.size() < trig_fifo_depth)
                    trig_q.push_back(hist.size());          // index of the word written now
                else
                    drops++;
            end
            hist.push_back(adc_dat);
            if (cbuf_rd_trig_wait)
                wait_seen = 1;
            if (acq_out_valid)
                check_word(acq_out_dat);
        end
    end
endmodule

`default_nettype wire

// File: verif/acq_tb.sv
`default_nettype none

module acq_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import acq_pkg::*;

    localparam int n_fills    = 4;
    localparam int min_gap    = 30;   // waveform time of 21 cycles plus 8, rounded up
    localparam int max_gap    = min_gap + 15;
    localparam int max_cycles = n_fills * (trig_fifo_depth * (max_gap + 2) + 120) + 500;

    logic                   adc_clk;
    logic                   reset_clk_adc;
    logic [adc_word_w-1:0]  adc_dat;
    logic                   trig;
    logic                   cbuf_rd_en;
    logic                   cbuf_trig_en;
    logic [out_word_w-1:0]  acq_out_dat;
    logic                   acq_out_valid;
    logic                   cbuf_rd_trig_wait;
    logic [drop_cnt_w-1:0]  trig_drop_cnt;
    int                     err_cnt;
    int                     chk_cnt;
    int                     fill_cnt;
    int                     cycle_cnt;
    int                     seed;
    int                     assert_errs;

    acq_readout_top dut0 (
        .adc_clk, .reset_clk_adc, .adc_dat, .trig, .cbuf_rd_en, .cbuf_trig_en,
        .acq_out_dat, .acq_out_valid, .cbuf_rd_trig_wait, .trig_drop_cnt
    );

    acq_monitor u_monitor (
        .adc_clk, .reset_clk_adc, .adc_dat, .trig, .cbuf_trig_en, .acq_out_dat,
        .acq_out_valid, .cbuf_rd_trig_wait, .trig_drop_cnt, .err_cnt, .chk_cnt, .fill_cnt
    );

    always #2 adc_clk = ~adc_clk;   // 4 ns period

    always @(posedge adc_clk) begin
        adc_dat <= $random(seed);     // new adc word every clock
    end

    // hard stop in case the sequencer never closes a fill
    always @(posedge adc_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // one trigger pulse, one clock wide
    task automatic pulse_trig();
        trig <= 1'b1;
        @(posedge adc_clk);
        trig <= 1'b0;
    endtask

    task automatic run_fill(input bit burst);
        int n;
        int gaps [8];
        int start;
        start = fill_cnt;
        @(negedge adc_clk);                     // random draws away from the clock edge
        if (!burst) begin
            n = ($random(seed) & 7) + 1;
            for (int k = 0; k < n; k++)
                gaps[k] = min_gap + ($random(seed) & 15);
        end
        repeat (2) begin                        // trigger disabled, must be ignored
            @(posedge adc_clk);
            pulse_trig();
        end
        @(posedge adc_clk);
        if (burst) begin
            cbuf_trig_en <= 1'b1;               // sequencer idle, fifo overflows
            @(posedge adc_clk);
            trig <= 1'b1;
            repeat (trig_fifo_depth + 2) @(posedge adc_clk);
            trig <= 1'b0;
        end
        cbuf_trig_en <= 1'b1;
        cbuf_rd_en   <= 1'b1;
        repeat (3) @(posedge adc_clk);
        cbuf_rd_en   <= 1'b0;                   // only idle looks at it
        if (!burst) begin
            for (int k = 0; k < n; k++) begin
                repeat (gaps[k]) @(posedge adc_clk);
                pulse_trig();
            end
            repeat (min_gap) @(posedge adc_clk);
        end
        cbuf_trig_en <= 1'b0;                   // close the fill
        while (fill_cnt == start)
            @(posedge adc_clk);
        repeat (5) @(posedge adc_clk);
    endtask

    initial begin
        seed          = 14169;
        cycle_cnt     = 0;
        adc_clk       = 1'b0;
        reset_clk_adc = 1'b1;
        adc_dat       = '0;
        trig          = 1'b0;
        cbuf_rd_en    = 1'b0;
        cbuf_trig_en  = 1'b0;
        repeat (3) @(posedge adc_clk);
        reset_clk_adc <= 1'b0;
        repeat (20) @(posedge adc_clk);      // pre-trigger words in the buffer
        for (int f = 0; f < n_fills; f++)
            run_fill(f == 2);
        repeat (10) @(posedge adc_clk);
        assert_errs = dut0.u_readout_seq.u_acq_assert.fail_cnt;
        $display("summary: %0d fills, %0d words checked, %0d errors, %0d assertion failures",
                 fill_cnt, chk_cnt, err_cnt, assert_errs);
        if (err_cnt == 0 && assert_errs == 0 && fill_cnt == n_fills)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end
endmodule

`default_nettype wire
